// ==== nird_pkg.sv ====
package nird_pkg;

  localparam int PIX_W  = 8;
  localparam int N_DIR  = 8;
  localparam int CODE_W = 4;
  // holds a full-scale 15x15 window
  localparam int SUM_W  = 16;

  typedef logic [PIX_W-1:0]  pixel_t;
  typedef logic [SUM_W-1:0]  sum_t;
  // 0..8 uniform, 9 non-uniform
  typedef logic [CODE_W-1:0] code_t;
  typedef logic [N_DIR-1:0]  pattern_t;

  // bit positions, counter-clockwise from east
  typedef enum logic [2:0] {
    DIR_E,
    DIR_NE,
    DIR_N,
    DIR_NW,
    DIR_W,
    DIR_SW,
    DIR_S,
    DIR_SE
  } dir_e;

  typedef struct packed {
    pixel_t [N_DIR-1:0] outer;
    pixel_t [N_DIR-1:0] inner;
  } ring_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    ring_t ring;
    sum_t  sum;
  } sampled_t;

  typedef struct packed {
    logic     valid;
    logic     last;
    pattern_t ni;
    pattern_t rd;
  } bits_t;

endpackage

// ==== window_buffer.sv ====
module window_buffer
  import nird_pkg::*;
#(
  parameter int COLS   = 8,
  parameter int ROWS   = 8,
  parameter int RADIUS = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  pixel_t                          pix_i,
  input  logic                            pix_valid_i,
  output pixel_t [2*RADIUS:0][2*RADIUS:0] win_o,
  output logic                            win_valid_o,
  output logic                            win_last_o
);

  localparam int SIDE = 2 * RADIUS + 1;
  localparam int CW   = $clog2(COLS + 1);
  localparam int RW   = $clog2(ROWS + 1);

  // position of the next pixel to be accepted
  logic [CW-1:0] col_q;
  logic [RW-1:0] row_q;
  logic          col_end;
  logic          row_end;
  logic          win_ok;

  // accepted pixel and its flags
  pixel_t pix_q;
  logic   acc_q;
  logic   ok_q;
  logic   last_q;

  // line k holds the row k+1 above the incoming one
  pixel_t [COLS-1:0] line_q [2*RADIUS];
  pixel_t [SIDE-1:0] new_col;

  assign col_end = (col_q == CW'(COLS - 1));
  assign row_end = (row_q == RW'(ROWS - 1));
  assign win_ok  = (col_q >= CW'(2 * RADIUS)) && (row_q >= RW'(2 * RADIUS));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      col_q       <= '0;
      row_q       <= '0;
      acc_q       <= 1'b0;
      ok_q        <= 1'b0;
      last_q      <= 1'b0;
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      acc_q       <= pix_valid_i;
      ok_q        <= pix_valid_i && win_ok;
      last_q      <= pix_valid_i && win_ok && col_end && row_end;
      win_valid_o <= ok_q;
      win_last_o  <= last_q;
      if (pix_valid_i) begin
        if (col_end) begin
          col_q <= '0;
          row_q <= row_end ? '0 : row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pix_q <= pix_i;
  end

  // bottom row is the current one, upper rows come from the line buffers
  always_comb begin
    new_col[SIDE-1] = pix_q;
    for (int k = 0; k < 2 * RADIUS; k++) begin
      new_col[SIDE-2-k] = line_q[k][COLS-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_q) begin
      line_q[0] <= {line_q[0][COLS-2:0], pix_q};
      for (int k = 1; k < 2 * RADIUS; k++) begin
        line_q[k] <= {line_q[k][COLS-2:0], line_q[k-1][COLS-1]};
      end
      // newest column enters on the east side
      for (int r = 0; r < SIDE; r++) begin
        win_o[r] <= {new_col[r], win_o[r][SIDE-1:1]};
      end
    end
  end

endmodule

// ==== patch_sampler.sv ====
module patch_sampler
  import nird_pkg::*;
#(
  parameter int RADIUS = 2
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  pixel_t [2*RADIUS:0][2*RADIUS:0] win_i,
  input  logic                            win_valid_i,
  input  logic                            win_last_i,
  output sampled_t                        sampled_o
);

  localparam int SIDE = 2 * RADIUS + 1;
  localparam int C    = RADIUS;

  typedef pixel_t [SIDE-1:0][SIDE-1:0] win_t;
  typedef pixel_t [N_DIR-1:0] dirs_t;

  // row index grows southward, column index eastward
  function automatic dirs_t ring_at(input win_t win, input int r);
    dirs_t s;
    s[DIR_E]  = win[C][C+r];
    s[DIR_NE] = win[C-r][C+r];
    s[DIR_N]  = win[C-r][C];
    s[DIR_NW] = win[C-r][C-r];
    s[DIR_W]  = win[C][C-r];
    s[DIR_SW] = win[C+r][C-r];
    s[DIR_S]  = win[C+r][C];
    s[DIR_SE] = win[C+r][C+r];
    return s;
  endfunction

  ring_t           ring_d;
  ring_t           ring1_q;
  ring_t           ring2_q;
  sum_t [SIDE-1:0] row_sum_d;
  sum_t [SIDE-1:0] row_sum_q;
  sum_t            total_d;
  sum_t            total_q;
  logic            valid1_q;
  logic            last1_q;
  logic            valid2_q;
  logic            last2_q;

  assign ring_d = '{outer: ring_at(win_i, RADIUS), inner: ring_at(win_i, RADIUS - 1)};

  always_comb begin
    for (int r = 0; r < SIDE; r++) begin
      row_sum_d[r] = '0;
      for (int c = 0; c < SIDE; c++) begin
        row_sum_d[r] = row_sum_d[r] + sum_t'(win_i[r][c]);
      end
    end
  end

  always_comb begin
    total_d = '0;
    for (int r = 0; r < SIDE; r++) begin
      total_d = total_d + row_sum_q[r];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid1_q <= 1'b0;
      last1_q  <= 1'b0;
      valid2_q <= 1'b0;
      last2_q  <= 1'b0;
    end else begin
      valid1_q <= win_valid_i;
      last1_q  <= win_valid_i && win_last_i;
      valid2_q <= valid1_q;
      last2_q  <= last1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    row_sum_q <= row_sum_d;
    ring1_q   <= ring_d;
    total_q   <= total_d;
    ring2_q   <= ring1_q;
  end

  assign sampled_o = '{valid: valid2_q, last: last2_q, ring: ring2_q, sum: total_q};

endmodule

// ==== descriptor_bits.sv ====
module descriptor_bits
  import nird_pkg::*;
#(
  parameter int RADIUS = 2
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  sampled_t sampled_i,
  output bits_t    bits_o
);

  // window area, scales a single sample up to the patch sum
  localparam int AREA = (2 * RADIUS + 1) * (2 * RADIUS + 1);

  pattern_t ni_d;
  pattern_t rd_d;
  pattern_t ni_q;
  pattern_t rd_q;
  logic     valid_q;
  logic     last_q;

  // ni compares against the patch mean without a divider
  always_comb begin
    for (int d = 0; d < N_DIR; d++) begin
      ni_d[d] = (sum_t'(sampled_i.ring.outer[d]) * sum_t'(AREA)) >= sampled_i.sum;
      rd_d[d] = sampled_i.ring.outer[d] >= sampled_i.ring.inner[d];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= sampled_i.valid;
      last_q  <= sampled_i.valid && sampled_i.last;
    end
  end

  always_ff @(posedge clk_i) begin
    ni_q <= ni_d;
    rd_q <= rd_d;
  end

  assign bits_o = '{valid: valid_q, last: last_q, ni: ni_q, rd: rd_q};

endmodule

// ==== riu2_mapper.sv ====
module riu2_mapper
  import nird_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  pattern_t pattern_i,
  input  logic     valid_i,
  input  logic     last_i,
  output code_t    code_o,
  output logic     done_o,
  output logic     frame_done_o
);

  localparam code_t NON_UNIFORM = code_t'(9);

  pattern_t changes;
  code_t    n_change;
  code_t    n_ones;
  code_t    code_d;

  // neighbour bit, wrapping from bit 0 round to the top
  assign changes  = pattern_i ^ {pattern_i[0], pattern_i[N_DIR-1:1]};
  assign n_change = code_t'($countones(changes));
  assign n_ones   = code_t'($countones(pattern_i));

  // uniform patterns have at most two 0/1 transitions
  assign code_d = (n_change <= code_t'(2)) ? n_ones : NON_UNIFORM;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_o       <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      done_o       <= valid_i;
      frame_done_o <= valid_i && last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    code_o <= code_d;
  end

endmodule

// ==== nird_top.sv ====
module nird_top
  import nird_pkg::*;
#(
  parameter int COLS   = 8,
  parameter int ROWS   = 8,
  parameter int RADIUS = 2
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  pixel_t pix_i,
  input  logic   pix_valid_i,
  output code_t  ni_o,
  output code_t  rd_o,
  output logic   done_o,
  output logic   frame_done_o
);

  pixel_t [2*RADIUS:0][2*RADIUS:0] win;
  logic                            win_valid;
  logic                            win_last;
  sampled_t                        sampled;
  bits_t                           bits;

  window_buffer #(
    .COLS  (COLS),
    .ROWS  (ROWS),
    .RADIUS(RADIUS)
  ) win_buf (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .pix_i      (pix_i),
    .pix_valid_i(pix_valid_i),
    .win_o      (win),
    .win_valid_o(win_valid),
    .win_last_o (win_last)
  );

  patch_sampler #(
    .RADIUS(RADIUS)
  ) sampler (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .win_i      (win),
    .win_valid_i(win_valid),
    .win_last_i (win_last),
    .sampled_o  (sampled)
  );

  descriptor_bits #(
    .RADIUS(RADIUS)
  ) desc (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .sampled_i(sampled),
    .bits_o   (bits)
  );

  // ni mapper carries the output strobes
  riu2_mapper ni_map (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .pattern_i   (bits.ni),
    .valid_i     (bits.valid),
    .last_i      (bits.last),
    .code_o      (ni_o),
    .done_o      (done_o),
    .frame_done_o(frame_done_o)
  );

  riu2_mapper rd_map (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .pattern_i   (bits.rd),
    .valid_i     (bits.valid),
    .last_i      (bits.last),
    .code_o      (rd_o),
    .done_o      (),
    .frame_done_o()
  );

endmodule

// ==== tb_nird.sv ====
module tb_nird
  import nird_pkg::*;
();

  localparam int COLS      = 8;
  localparam int ROWS      = 8;
  localparam int RADIUS    = 2;
  localparam int AREA      = (2 * RADIUS + 1) * (2 * RADIUS + 1);
  localparam int PER_FRAME = (COLS - 2 * RADIUS) * (ROWS - 2 * RADIUS);
  localparam int MAX_TESTS = 64;
  localparam logic [31:0] SEED = 32'h37467522;

  typedef enum {MODE_FLAT, MODE_RAMP, MODE_RANDOM} mode_e;

  // one expected result, in raster order
  typedef struct packed {
    logic [7:0] test;
    logic       last;
    code_t      ni;
    code_t      rd;
  } expect_t;

  logic   clk;
  logic   rst;
  pixel_t pix;
  logic   pix_valid;
  code_t  ni;
  code_t  rd;
  logic   done;
  logic   frame_done;

  string t_name [MAX_TESTS];
  mode_e t_mode [MAX_TESTS];
  int    t_base [MAX_TESTS];
  int    t_step [MAX_TESTS];
  int    t_gap  [MAX_TESTS];
  int    t_ni   [MAX_TESTS];
  int    t_rd   [MAX_TESTS];
  int    t_err  [MAX_TESTS];

  expect_t     sb_q[$];
  pixel_t      img [ROWS][COLS];
  logic [31:0] rng = SEED;
  int          n_tests = 0;
  int          tests_done = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          other_err = 0;
  int          frame_cnt = 0;
  int          cycles = 0;
  int          limit = 100;
  bit          timed_out = 1'b0;

  nird_top #(
    .COLS  (COLS),
    .ROWS  (ROWS),
    .RADIUS(RADIUS)
  ) nird_top_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .pix_i       (pix),
    .pix_valid_i (pix_valid),
    .ni_o        (ni),
    .rd_o        (rd),
    .done_o      (done),
    .frame_done_o(frame_done)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic code_t riu2_code(input pattern_t p);
    int flips;
    int ones;
    flips = 0;
    ones  = 0;
    for (int d = 0; d < N_DIR; d++) begin
      if (p[d] != p[(d + 1) % N_DIR]) begin
        flips++;
      end
      if (p[d]) begin
        ones++;
      end
    end
    return (flips <= 2) ? code_t'(ones) : code_t'(9);
  endfunction

  // offsets in bit order E, NE, N, NW, W, SW, S, SE; y grows downward
  function automatic void ref_patterns(input int y, input int x,
                                       output pattern_t ni_p, output pattern_t rd_p);
    int dy [N_DIR] = '{0, -1, -1, -1, 0, 1, 1, 1};
    int dx [N_DIR] = '{1, 1, 0, -1, -1, -1, 0, 1};
    int sum;
    int outer;
    int inner;
    sum = 0;
    for (int r = -RADIUS; r <= RADIUS; r++) begin
      for (int c = -RADIUS; c <= RADIUS; c++) begin
        sum += img[y + r][x + c];
      end
    end
    for (int d = 0; d < N_DIR; d++) begin
      outer   = img[y + dy[d] * RADIUS][x + dx[d] * RADIUS];
      inner   = img[y + dy[d] * (RADIUS - 1)][x + dx[d] * (RADIUS - 1)];
      ni_p[d] = (outer * AREA >= sum);
      rd_p[d] = (outer >= inner);
    end
  endfunction

  task automatic read_tests();
    int    fd;
    int    cnt;
    int    base;
    int    step;
    int    gap;
    int    eni;
    int    erd;
    string line;
    string name;
    string mode;
    fd = $fopen("nird_tests.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open nird_tests.txt");
      other_err++;
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (cnt <= 0 || line[0] == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%s %s %d %d %d %d %d", name, mode, base, step, gap, eni, erd);
      if (cnt <= 0) begin
        continue;
      end
      if (cnt != 7) begin
        $display("error: malformed line in nird_tests.txt: %s", line);
        other_err++;
        continue;
      end
      case (mode)
        "flat":   t_mode[n_tests] = MODE_FLAT;
        "ramp":   t_mode[n_tests] = MODE_RAMP;
        "random": t_mode[n_tests] = MODE_RANDOM;
        default: begin
          $display("error: unknown stimulus mode %s in test %s", mode, name);
          other_err++;
          continue;
        end
      endcase
      t_name[n_tests] = name;
      t_base[n_tests] = base;
      t_step[n_tests] = step;
      t_gap[n_tests]  = gap;
      t_ni[n_tests]   = eni;
      t_rd[n_tests]   = erd;
      t_err[n_tests]  = 0;
      n_tests++;
    end
    $fclose(fd);
    if (n_tests == 0) begin
      $display("error: no tests found in nird_tests.txt");
      other_err++;
    end
  endtask

  task automatic build_frame(input int t);
    // random frames restart from the seed so repeated tests see the same image
    if (t_mode[t] == MODE_RANDOM) begin
      rng = SEED;
    end
    for (int y = 0; y < ROWS; y++) begin
      for (int x = 0; x < COLS; x++) begin
        case (t_mode[t])
          MODE_FLAT: img[y][x] = pixel_t'(t_base[t]);
          MODE_RAMP: img[y][x] = pixel_t'(t_base[t] + t_step[t] * x);
          default: begin
            rng       = lcg_next(rng);
            img[y][x] = rng[23:16];
          end
        endcase
      end
    end
  endtask

  task automatic push_expected(input int t);
    pattern_t ni_p;
    pattern_t rd_p;
    expect_t  e;
    for (int y = RADIUS; y < ROWS - RADIUS; y++) begin
      for (int x = RADIUS; x < COLS - RADIUS; x++) begin
        ref_patterns(y, x, ni_p, rd_p);
        e.test = 8'(t);
        e.last = (y == ROWS - 1 - RADIUS) && (x == COLS - 1 - RADIUS);
        e.ni   = (t_ni[t] < 0) ? riu2_code(ni_p) : code_t'(t_ni[t]);
        e.rd   = (t_rd[t] < 0) ? riu2_code(rd_p) : code_t'(t_rd[t]);
        sb_q.push_back(e);
      end
    end
  endtask

  task automatic drive_frame(input int t);
    int idle;
    for (int y = 0; y < ROWS; y++) begin
      for (int x = 0; x < COLS; x++) begin
        idle = 0;
        if (t_gap[t] > 0) begin
          rng  = lcg_next(rng);
          idle = int'(rng[15:8]) % (t_gap[t] + 1);
        end
        repeat (idle) begin
          @(posedge clk);
          #1;
          pix_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        pix       = img[y][x];
        pix_valid = 1'b1;
      end
    end
  endtask

  task automatic run_all();
    for (int t = 0; t < n_tests; t++) begin
      build_frame(t);
      push_expected(t);
      drive_frame(t);
    end
    @(posedge clk);
    #1;
    pix_valid = 1'b0;
  endtask

  task automatic check_result();
    expect_t e;
    int      t;
    e = sb_q.pop_front();
    t = int'(e.test);
    assert (ni == e.ni) else begin
      $display("MISMATCH %s ni expected %0d actual %0d", t_name[t], e.ni, ni);
      t_err[t]++;
    end
    assert (rd == e.rd) else begin
      $display("MISMATCH %s rd expected %0d actual %0d", t_name[t], e.rd, rd);
      t_err[t]++;
    end
    assert (frame_done == e.last) else begin
      $display("error: %s frame_done_o is %0b where %0b was expected",
               t_name[t], frame_done, e.last);
      t_err[t]++;
    end
    if (frame_done) begin
      assert (frame_cnt == PER_FRAME) else begin
        $display("error: %s frame ended after %0d results instead of %0d",
                 t_name[t], frame_cnt, PER_FRAME);
        t_err[t]++;
      end
      frame_cnt = 0;
    end
    if (e.last) begin
      if (t_err[t] == 0) begin
        $display("test %s: ok, %0d results", t_name[t], PER_FRAME);
        n_pass++;
      end else begin
        $display("test %s: FAILED with %0d errors", t_name[t], t_err[t]);
        n_fail++;
      end
      tests_done++;
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!rst) begin
      assert (!frame_done || done) else begin
        $display("error: frame_done_o high without done_o");
        other_err++;
      end
      if (done) begin
        frame_cnt = frame_cnt + 1;
        assert (sb_q.size() > 0) else begin
          $display("error: done_o pulse with no result expected");
          other_err++;
        end
        if (sb_q.size() > 0) begin
          check_result();
        end
      end
    end
  end

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    pix       = '0;
    pix_valid = 1'b0;
    read_tests();
    for (int t = 0; t < n_tests; t++) begin
      limit += COLS * ROWS * (t_gap[t] + 1);
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      run_all();
    join_none
    while (tests_done < n_tests && cycles < limit) begin
      @(posedge clk);
    end
    if (tests_done < n_tests) begin
      $display("timeout: results missing");
      timed_out = 1'b1;
    end else begin
      // catch stray pulses after the last frame
      repeat (10) @(posedge clk);
    end
    $display("tests passed: %0d, failed: %0d, other errors: %0d", n_pass, n_fail, other_err);
    if (n_fail == 0 && other_err == 0 && !timed_out && n_tests > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== nird_tests.txt ====
# columns: name mode base step gap expected_ni expected_rd
# mode is flat, ramp or random; an expected code of -1 is taken from the model
flat_100       flat    100   0  0   8   8
ramp_4         ramp     20   4  0   5   5
random_nogap   random    0   0  0  -1  -1
random_gap3    random    0   0  3  -1  -1
flat_dark      flat      0   0  0   8   8
flat_gap2      flat    200   0  2   8   8
ramp_down      ramp     60  -4  1   5   5
ramp_model     ramp     30   3  0  -1  -1
random_again   random    0   0  0  -1  -1

// ==== all.f ====
nird_pkg.sv
window_buffer.sv
patch_sampler.sv
descriptor_bits.sv
riu2_mapper.sv
nird_top.sv
tb_nird.sv

// ==== Bender.yml ====
package:
  name: nird

sources:
  - nird_pkg.sv
  - window_buffer.sv
  - patch_sampler.sv
  - descriptor_bits.sv
  - riu2_mapper.sv
  - nird_top.sv
  - target: test
    files:
      - tb_nird.sv
